//--- Makefile
# Verilator build and run for the norm check testbench

VERILATOR ?= verilator
TOP       ?= norm_check_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL CHECKS PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+include
verilog/ntt_defines_pkg.sv
verilog/norm_check_defines_pkg.sv
verilog/norm_check_mem.sv
verilog/norm_check_ctrl.sv
verilog/norm_check_unit.sv
verilog/norm_check_top.sv
verif/norm_check_tb.sv

//--- include/norm_check_defines.svh
//--------------------------------------------------------------------------
// Sizes, widths, modulus and norm bounds for the coefficient-bound check.
// Included by the packages, the RTL and the testbench.
//--------------------------------------------------------------------------
`ifndef NORM_CHECK_DEFINES_SVH
`define NORM_CHECK_DEFINES_SVH

// Polynomial and vector sizes, scaled down for simulation
`define NC_N                32
`define NC_L                4
`define NC_K                6

// Coefficient and memory word layout
`define NC_COEFF_W          24
`define NC_COEFFS_PER_WORD  4
`define NC_LANES            8
`define NC_MEM_ADDR_W       8

// Modulus q
`define NC_Q                8380417

// Rounding and rejection parameters
`define NC_GAMMA1           524288
`define NC_GAMMA2           261888
`define NC_BETA             120

// Bounds per mode, a coefficient at or above its bound is invalid
`define NC_Z_BOUND          (`NC_GAMMA1 - `NC_BETA)
`define NC_R0_BOUND         (`NC_GAMMA2 - `NC_BETA)
`define NC_CT0_BOUND        4096

`endif

//--- verif/norm_check_stim.txt
# W addr c0 c1 c2 c3 : load one word, hex coefficients, c0 in the low bits
# C name mode base expected_invalid : mode 0 z, 1 r0, 2 ct0; base in hex
# Base 00: clean vector, values near the ct0 bound and near q
W 00 000FFF 7FD002 7FE000 000001
W 17 7FE000 7FE000 000FFF 7FD002
W 2F 7FD002 000FFF 000000 000FFF
# Base 30: z bound minus one passes, z bound in the last lane fails
W 31 77E07A 000000 000000 000000
W 4E 000000 000000 000000 07FF87
W 4F 000000 000000 000000 07FF88
# Base 60: r0 bound minus one, then negative r0 bound in the last lane
W 61 000000 000000 03FE87 000000
W 8F 000000 000000 000000 7BE179
# Base 90: ct0 bound exactly
W 95 000000 001000 000000 000000
# Base C0: offender just past the L polynomials
W E0 100000 000000 000000 000000
C clean_z        0 00 0
C clean_r0       1 00 0
C clean_ct0      2 00 0
C z_last_lane    0 30 1
C z_after_fail   0 00 0
C r0_last_lane   1 60 1
C r0_after_fail  1 00 0
C z_near_bound   0 60 0
C ct0_exact      2 90 1
C ct0_val_in_r0  1 90 0
C len_z          0 C0 0
C len_r0         1 C0 1
C len_ct0        2 C0 1

//--- verif/norm_check_tb.sv
//--------------------------------------------------------------------------
// Testbench for the norm check subsystem. Loads memory and runs the checks
// listed in the stim file through the req/ack handshake.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "norm_check_defines.svh"

module norm_check_tb
    import ntt_defines_pkg::*;
    import norm_check_defines_pkg::*;
();

    localparam int ACK_TIMEOUT = 200;
    localparam int NAME_W      = 8 * 24;
    localparam int LINE_W      = 8 * 160;
    // Enable pulse and start, one cycle per word pair, pipeline drain and ack
    localparam int Z_LATENCY   = 2 + `NC_L * `NC_N / `NC_LANES + 2;
    localparam int KV_LATENCY  = 2 + `NC_K * `NC_N / `NC_LANES + 2;

    logic           clk = 1'b0;
    logic           reset_n;
    logic           zeroize;
    logic           check_req;
    chk_norm_mode_t mode;
    mem_addr_t      mem_base_addr;
    logic           wr_en;
    mem_addr_t      wr_addr;
    mem_data_t      wr_data;
    logic           check_ack;
    logic           invalid;

    // Last check of the stim file is replayed around a zeroize
    logic [NAME_W-1:0] last_name;
    chk_norm_mode_t    last_mode;
    mem_addr_t         last_base;
    logic              last_exp;
    int                check_count;

    always #5 clk = ~clk;

    norm_check_top dut0 (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .check_req     (check_req),
        .mode          (mode),
        .mem_base_addr (mem_base_addr),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .check_ack     (check_ack),
        .invalid       (invalid)
    );

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic load_word(input mem_addr_t addr, input mem_data_t data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        step_cycle();
        wr_en   = 1'b0;
    endtask

    // Each coefficient built from its full address and lane
    // Largest value stays under the ct0 bound
    task automatic fill_memory();
        int a;
        int j;
        mem_data_t word;
        for (a = 0; a < (1 << `NC_MEM_ADDR_W); a++) begin
            for (j = 0; j < `NC_COEFFS_PER_WORD; j++)
                word[j*`NC_COEFF_W +: `NC_COEFF_W] = coeff_t'(a * `NC_COEFFS_PER_WORD + j);
            load_word(mem_addr_t'(a), word);
        end
    endtask

    // Cycles are counted from the drive point until ack reaches the level
    task automatic wait_for_ack(input logic level, input logic [NAME_W-1:0] name,
                                output int cycles);
        cycles = 0;
        while (check_ack !== level) begin
            if (cycles >= ACK_TIMEOUT) begin
                $display("Timeout in test %0s while waiting for check_ack to become %0d",
                         name, level);
                stop_on_failure();
            end else begin
                step_cycle();
                cycles++;
            end
        end
    endtask

    task automatic run_check(input logic [NAME_W-1:0] name, input chk_norm_mode_t m,
                             input mem_addr_t base, input logic exp_invalid);
        int cycles;
        int hold;
        int latency;
        int i;
        // z walks L polynomials, r0 and ct0 walk K
        latency       = (m == z_bound) ? Z_LATENCY : KV_LATENCY;
        mode          = m;
        mem_base_addr = base;
        check_req     = 1'b1;
        wait_for_ack(1'b1, name, cycles);
        assert (cycles == latency) else begin
            $display("ERR %0s: ack latency expected %0d actual %0d", name, latency, cycles);
            stop_on_failure();
        end
        assert (invalid == exp_invalid) else begin
            $display("ERR %0s: invalid expected %0d actual %0d", name, exp_invalid, invalid);
            stop_on_failure();
        end
        // Ack and result hold while the requester stalls
        hold = int'($urandom % 4);
        for (i = 0; i < hold; i++) begin
            step_cycle();
            assert (check_ack == 1'b1 && invalid == exp_invalid) else begin
                $display("ERR %0s: ack/invalid during stall expected 1/%0d actual %0d/%0d",
                         name, exp_invalid, check_ack, invalid);
                stop_on_failure();
            end
        end
        check_req = 1'b0;
        wait_for_ack(1'b0, name, cycles);
        assert (cycles == 1) else begin
            $display("ERR %0s: ack fall delay expected 1 actual %0d", name, cycles);
            stop_on_failure();
        end
        hold = int'($urandom % 3);
        for (i = 0; i < hold; i++)
            step_cycle();
        $display("Test %0s done with invalid %0d", name, invalid);
    endtask

    task automatic run_stim_file();
        int fd;
        int n;
        int mode_val;
        int exp_val;
        logic [LINE_W-1:0] line_buf;
        logic [7:0] tag;
        logic [NAME_W-1:0] name;
        mem_addr_t addr;
        coeff_t c0, c1, c2, c3;
        fd = $fopen("verif/norm_check_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/norm_check_stim.txt for reading");
            stop_on_failure();
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                tag      = '0;
                n        = $fgets(line_buf, fd);
                if (n > 0)
                    n = $sscanf(line_buf, "%s", tag);
                // Comment and blank lines leave the tag unmatched
                if (tag == "W") begin
                    n = $sscanf(line_buf, "W %h %h %h %h %h", addr, c0, c1, c2, c3);
                    assert (n == 5) else begin
                        $display("Malformed load line in the stim file: %0s", line_buf);
                        stop_on_failure();
                    end
                    load_word(addr, {c3, c2, c1, c0});
                end else if (tag == "C") begin
                    n = $sscanf(line_buf, "C %s %d %h %d", name, mode_val, addr, exp_val);
                    assert (n == 4) else begin
                        $display("Malformed check line in the stim file: %0s", line_buf);
                        stop_on_failure();
                    end
                    last_name = name;
                    last_mode = chk_norm_mode_t'(mode_val[1:0]);
                    last_base = addr;
                    last_exp  = exp_val[0];
                    check_count++;
                    run_check(last_name, last_mode, last_base, last_exp);
                end
            end
            $fclose(fd);
        end
    endtask

    // Abort a running check late in its walk, then repeat it to completion
    task automatic zeroize_mid_check(input logic [NAME_W-1:0] name, input chk_norm_mode_t m,
                                     input mem_addr_t base, input logic exp_invalid);
        int wait_cycles;
        int latency;
        int i;
        // Zeroize hits while reads still run and after an early offender set the flag
        latency       = (m == z_bound) ? Z_LATENCY : KV_LATENCY;
        wait_cycles   = latency - 8 + int'($urandom % 5);
        mode          = m;
        mem_base_addr = base;
        check_req     = 1'b1;
        for (i = 0; i < wait_cycles; i++)
            step_cycle();
        zeroize   = 1'b1;
        check_req = 1'b0;
        step_cycle();
        zeroize   = 1'b0;
        assert (invalid == 1'b0) else begin
            $display("ERR %0s: invalid after zeroize expected 0 actual %0d", name, invalid);
            stop_on_failure();
        end
        // No ack may show up for longer than a full walk
        for (i = 0; i < KV_LATENCY + 8; i++) begin
            step_cycle();
            assert (check_ack == 1'b0) else begin
                $display("ERR %0s: check_ack after zeroize expected 0 actual %0d",
                         name, check_ack);
                stop_on_failure();
            end
        end
        run_check(name, m, base, exp_invalid);
    endtask

    initial begin
        void'($urandom(90));
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        check_req     = 1'b0;
        mode          = z_bound;
        mem_base_addr = '0;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        check_count   = 0;
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        fill_memory();
        run_stim_file();
        if (check_count == 0) begin
            $display("The stim file holds no check lines");
            stop_on_failure();
        end else begin
            zeroize_mid_check(last_name, last_mode, last_base, last_exp);
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- verilog/norm_check_ctrl.sv
//--------------------------------------------------------------------------
// Read sequencer for the norm check. One enable walks every polynomial of
// the selected vector, reading an even and an odd word each cycle.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "norm_check_defines.svh"

module norm_check_ctrl
    import ntt_defines_pkg::*;
    import norm_check_defines_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,
    input  logic           norm_check_enable,
    input  chk_norm_mode_t mode,
    input  mem_addr_t      mem_base_addr,
    output mem_if_t        mem_a_rd_req,
    output mem_if_t        mem_b_rd_req,
    output logic           check_enable,
    output logic           norm_check_done
);

    chk_read_state_e state_ps;
    chk_read_state_e state_ns;

    // Index of the word pair being read
    mem_addr_t pair_idx;
    // Final word of the vector, read on port B
    mem_addr_t last_addr;
    logic [7:0] num_poly;

    logic incr_pair;
    logic last_pair_addr;

    // Pair counter, wraps to zero after the final pair
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            pair_idx <= '0;
        else if (zeroize)
            pair_idx <= '0;
        else if (incr_pair)
            pair_idx <= last_pair_addr ? '0 : pair_idx + mem_addr_t'(1);
    end

    // Even word on A, the following odd word on B
    always_comb begin
        mem_a_rd_req.addr = (pair_idx << 1) + mem_base_addr;
        mem_b_rd_req.addr = (pair_idx << 1) + mem_base_addr + mem_addr_t'(1);

        // Both ports read in every walk cycle
        mem_a_rd_req.rd_wr_en = (state_ps == CHK_RD_MEM) ? RW_READ : RW_IDLE;
        mem_b_rd_req.rd_wr_en = (state_ps == CHK_RD_MEM) ? RW_READ : RW_IDLE;
    end

    // Vector length follows the mode
    always_comb begin
        case (mode)
            z_bound:   num_poly = 8'(`NC_L);
            r0_bound:  num_poly = 8'(`NC_K);
            ct0_bound: num_poly = 8'(`NC_K);
            default:   num_poly = 8'(`NC_L);
        endcase
    end

    // Four coefficients per word
    always_comb begin
        last_addr = mem_base_addr + mem_addr_t'(num_poly * (`NC_N / `NC_COEFFS_PER_WORD))
                    - mem_addr_t'(1);
        last_pair_addr = (mem_b_rd_req.addr == last_addr);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state_ps <= CHK_IDLE;
        else if (zeroize)
            state_ps <= CHK_IDLE;
        else
            state_ps <= state_ns;
    end

    always_comb begin
        state_ns  = state_ps;
        incr_pair = 1'b0;
        case (state_ps)
            CHK_IDLE: begin
                // Enable seen here, first read on the next cycle
                state_ns = norm_check_enable ? CHK_RD_MEM : CHK_IDLE;
            end
            CHK_RD_MEM: begin
                incr_pair = 1'b1;
                state_ns  = last_pair_addr ? CHK_IDLE : CHK_RD_MEM;
            end
            default: begin
                state_ns = CHK_IDLE;
            end
        endcase
    end

    // Datapath qualifier and idle status
    always_comb begin
        check_enable    = (state_ps == CHK_RD_MEM);
        norm_check_done = (state_ps == CHK_IDLE);
    end

endmodule

//--- verilog/norm_check_defines_pkg.sv
//--------------------------------------------------------------------------
// Check-side types for the norm check controller, datapath and top level.
//--------------------------------------------------------------------------
`include "norm_check_defines.svh"

package norm_check_defines_pkg;

    // One polynomial coefficient in [0, q)
    typedef logic [`NC_COEFF_W-1:0] coeff_t;

    // Bound selection, also picks the vector length
    // z uses L polynomials, r0 and ct0 use K polynomials
    typedef enum logic [1:0] {
        z_bound   = 2'b00,
        r0_bound  = 2'b01,
        ct0_bound = 2'b10
    } chk_norm_mode_t;

    // Read sequencer states
    typedef enum logic {
        CHK_IDLE   = 1'b0,
        CHK_RD_MEM = 1'b1
    } chk_read_state_e;

endpackage

//--- verilog/norm_check_mem.sv
//--------------------------------------------------------------------------
// Coefficient memory with two registered read ports and a load port.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "norm_check_defines.svh"

module norm_check_mem
    import ntt_defines_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  mem_if_t   mem_a_rd_req,
    input  mem_if_t   mem_b_rd_req,
    input  logic      wr_en,
    input  mem_addr_t wr_addr,
    input  mem_data_t wr_data,
    output mem_data_t rd_data_a,
    output mem_data_t rd_data_b
);

    // Word storage, contents are loaded before any check
    mem_data_t mem_array [0:(1 << `NC_MEM_ADDR_W)-1];

    // Load port, one word per cycle
    always_ff @(posedge clk) begin
        if (wr_en)
            mem_array[wr_addr] <= wr_data;
    end

    // Port A, even words of the walk
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            rd_data_a <= '0;
        else if (mem_a_rd_req.rd_wr_en == RW_READ)
            rd_data_a <= mem_array[mem_a_rd_req.addr];
    end

    // Port B, odd words of the walk
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            rd_data_b <= '0;
        else if (mem_b_rd_req.rd_wr_en == RW_READ)
            rd_data_b <= mem_array[mem_b_rd_req.addr];
    end

endmodule

//--- verilog/norm_check_top.sv
//--------------------------------------------------------------------------
// Norm check subsystem. A four-phase req/ack handshake starts one check
// of the selected vector and returns the invalid result.
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module norm_check_top
    import ntt_defines_pkg::*;
    import norm_check_defines_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,
    input  logic           check_req,
    input  chk_norm_mode_t mode,
    input  mem_addr_t      mem_base_addr,
    input  logic           wr_en,
    input  mem_addr_t      wr_addr,
    input  mem_data_t      wr_data,
    output logic           check_ack,
    output logic           invalid
);

    mem_if_t   mem_a_rd_req;
    mem_if_t   mem_b_rd_req;
    mem_data_t rd_data_a;
    mem_data_t rd_data_b;

    logic busy;
    logic norm_check_enable;
    logic norm_check_done;
    logic check_enable;
    logic check_active;
    logic start_check;
    logic check_finished;

    // New request only once the previous ack has fallen
    assign start_check = check_req && !busy && !check_ack;

    // Walk over and last data through the comparator
    assign check_finished = busy && !check_ack && !norm_check_enable
                            && norm_check_done && !check_active;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy              <= 1'b0;
            norm_check_enable <= 1'b0;
            check_ack         <= 1'b0;
        end else if (zeroize) begin
            busy              <= 1'b0;
            norm_check_enable <= 1'b0;
            check_ack         <= 1'b0;
        end else begin
            // Enable is a single-cycle pulse
            norm_check_enable <= start_check;
            if (start_check) begin
                busy <= 1'b1;
            end else if (check_finished) begin
                check_ack <= 1'b1;
            end else if (check_ack && !check_req) begin
                check_ack <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

    norm_check_ctrl ctrl0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .norm_check_enable (norm_check_enable),
        .mode              (mode),
        .mem_base_addr     (mem_base_addr),
        .mem_a_rd_req      (mem_a_rd_req),
        .mem_b_rd_req      (mem_b_rd_req),
        .check_enable      (check_enable),
        .norm_check_done   (norm_check_done)
    );

    norm_check_mem mem0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .mem_a_rd_req (mem_a_rd_req),
        .mem_b_rd_req (mem_b_rd_req),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b)
    );

    // Enable pulse doubles as the flag clear
    norm_check_unit unit0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .clear        (norm_check_enable),
        .check_enable (check_enable),
        .mode         (mode),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .check_active (check_active),
        .invalid      (invalid)
    );

endmodule

//--- verilog/norm_check_unit.sv
//--------------------------------------------------------------------------
// Eight-lane norm comparator. Centres each coefficient modulo q, compares
// its magnitude with the mode bound and keeps a sticky invalid flag.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "norm_check_defines.svh"

module norm_check_unit
    import ntt_defines_pkg::*;
    import norm_check_defines_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  logic           zeroize,
    input  logic           clear,
    input  logic           check_enable,
    input  chk_norm_mode_t mode,
    input  mem_data_t      rd_data_a,
    input  mem_data_t      rd_data_b,
    output logic           check_active,
    output logic           invalid
);

    coeff_t lane [`NC_LANES];
    coeff_t mag  [`NC_LANES];
    coeff_t bound;
    logic [`NC_LANES-1:0] lane_fail;

    // Enable delayed by the memory read latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            check_active <= 1'b0;
        else if (zeroize)
            check_active <= 1'b0;
        else
            check_active <= check_enable;
    end

    // Bound for the active mode
    always_comb begin
        case (mode)
            z_bound:   bound = coeff_t'(`NC_Z_BOUND);
            r0_bound:  bound = coeff_t'(`NC_R0_BOUND);
            ct0_bound: bound = coeff_t'(`NC_CT0_BOUND);
            default:   bound = coeff_t'(`NC_CT0_BOUND);
        endcase
    end

    always_comb begin
        for (int i = 0; i < `NC_COEFFS_PER_WORD; i++) begin
            // Port A fills lanes 0 to 3 and port B lanes 4 to 7
            lane[i] = rd_data_a[i*`NC_COEFF_W +: `NC_COEFF_W];
            lane[i+`NC_COEFFS_PER_WORD] = rd_data_b[i*`NC_COEFF_W +: `NC_COEFF_W];
        end
        for (int i = 0; i < `NC_LANES; i++) begin
            // Upper half of [0, q) stands for negative values
            if (lane[i] <= coeff_t'((`NC_Q - 1) / 2))
                mag[i] = lane[i];
            else
                mag[i] = coeff_t'(`NC_Q) - lane[i];
            lane_fail[i] = (mag[i] >= bound);
        end
    end

    // Sticky flag, cleared at the start of every check
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            invalid <= 1'b0;
        else if (zeroize || clear)
            invalid <= 1'b0;
        else if (check_active && (|lane_fail))
            invalid <= 1'b1;
    end

endmodule

//--- verilog/ntt_defines_pkg.sv
//--------------------------------------------------------------------------
// Memory-side types shared by the coefficient memory and its users.
//--------------------------------------------------------------------------
`include "norm_check_defines.svh"

package ntt_defines_pkg;

    // Word address into the coefficient memory
    typedef logic [`NC_MEM_ADDR_W-1:0] mem_addr_t;

    // One memory word, four coefficients with lane 0 in the low bits
    typedef logic [`NC_COEFF_W*`NC_COEFFS_PER_WORD-1:0] mem_data_t;

    // Command carried with each memory request
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rw_cmd_e;

    // Memory request, command plus word address
    typedef struct packed {
        rw_cmd_e   rd_wr_en;
        mem_addr_t addr;
    } mem_if_t;

endpackage
